// ==== run_sim.sh ====
#!/bin/sh
# compile and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f verilog.f --top-module pipe4_decd_tb -o pipe4_decd_sim
./obj_dir/pipe4_decd_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "TEST OK" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== verification/pipe4_decd_asserts.sv ====
// bound into pipe4_decd_top; PIPE_DEPTH comes from the bound instance, most checks idle in reset
`timescale 1ns/100ps
module pipe4_decd_asserts #(
  parameter int PIPE_DEPTH = 2
) (
  input logic                 forever_cpuclk,
  input logic                 rst_n,
  input logic                 opcode_vld,
  input logic                 decd_vld,
  input pipe4_pkg::decd_out_t decd
);

  //============================================================
  //  valid timing
  //============================================================
  vld_low_in_reset: assert property (
    @(posedge forever_cpuclk) !rst_n |-> !decd_vld
  ) else $error("decd_vld high while rst_n is low");

  // fixed latency, one output per input
  vld_latency: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n)
    decd_vld == $past(opcode_vld, PIPE_DEPTH)
  ) else $error("decd_vld does not follow opcode_vld by PIPE_DEPTH cycles");

  //============================================================
  //  bundle sanity
  //============================================================
  shift_onehot: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n)
    decd_vld |-> $onehot(decd.shift)
  ) else $error("shift is not one-hot");

  atomic_is_store: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n)
    (decd_vld && !decd.illegal && decd.atomic) |-> decd.st
  ) else $error("atomic set without st");   // sc and amo both store

endmodule

bind pipe4_decd_top pipe4_decd_asserts #(
  .PIPE_DEPTH (PIPE_DEPTH)
) u_asserts (
  .forever_cpuclk (forever_cpuclk),
  .rst_n          (rst_n),
  .opcode_vld     (opcode_vld),
  .decd_vld       (decd_vld),
  .decd           (decd)
);

// ==== verification/pipe4_decd_tb.sv ====
// single clock, no back-pressure; the model knows only the store, amo, barrier and cache/tlb classes
`timescale 1ns/100ps
module pipe4_decd_tb;

  localparam int PIPE_DEPTH     = 2;
  localparam int NUM_CYCLES     = 2000;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + PIPE_DEPTH + 4 + 100;
  localparam int NUM_ROWS       = 14;

  // opcode pattern rows shared by stimulus and model
  localparam int ROW_NONE     = -1;
  localparam int ROW_SC       = 0;
  localparam int ROW_STPTR    = 1;
  localparam int ROW_ST       = 2;
  localparam int ROW_FST      = 3;
  localparam int ROW_STX      = 4;
  localparam int ROW_FSTX     = 5;
  localparam int ROW_STBOUND  = 6;
  localparam int ROW_FSTBOUND = 7;
  localparam int ROW_AMO      = 8;
  localparam int ROW_AMO_DB   = 9;
  localparam int ROW_IBAR     = 10;
  localparam int ROW_DBAR     = 11;
  localparam int ROW_CACOP    = 12;
  localparam int ROW_INVTLB   = 13;

  typedef struct packed {
    logic [31:0] mask;
    logic [31:0] value;
  } pattern_t;

  typedef struct packed {
    logic [31:0]             opcode;
    pipe4_pkg::decd_out_t    decd;
    pipe4_pkg::offset_plus_t offset_plus;
  } expect_t;

  logic                    forever_cpuclk;
  logic                    rst_n;
  logic                    opcode_vld;
  logic [31:0]             opcode;
  logic [6:0]              dst_preg;
  logic                    decd_vld;
  pipe4_pkg::decd_out_t    decd;
  pipe4_pkg::offset_plus_t decd_offset_plus;

  logic [31:0] rng_state;
  expect_t     exp_queue [$];
  int          cycle_count;
  int          checked_count;
  int          cyc;

  pipe4_decd_top #(
    .PIPE_DEPTH (PIPE_DEPTH)
  ) u_dut (
    .forever_cpuclk   (forever_cpuclk),
    .rst_n            (rst_n),
    .opcode_vld       (opcode_vld),
    .opcode           (opcode),
    .dst_preg         (dst_preg),
    .decd_vld         (decd_vld),
    .decd             (decd),
    .decd_offset_plus (decd_offset_plus)
  );

  initial
  begin
    forever_cpuclk = 1'b0;
    forever #5 forever_cpuclk = ~forever_cpuclk;
  end

  //============================================================
  //  random source and opcode patterns
  //============================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // value holds zeros outside the mask
  function automatic pattern_t pattern_row(input int row);
    pattern_t p;
    case (row)
      ROW_SC:       p = {32'hfd00_0000, 32'h2100_0000};
      ROW_STPTR:    p = {32'hfd00_0000, 32'h2500_0000};
      ROW_ST:       p = {32'hff00_0000, 32'h2900_0000};
      ROW_FST:      p = {32'hff40_0000, 32'h2b40_0000};
      ROW_STX:      p = {32'hfff3_8000, 32'h3810_0000};
      ROW_FSTX:     p = {32'hfffb_8000, 32'h3838_0000};
      ROW_STBOUND:  p = {32'hfffc_0000, 32'h387c_0000};
      ROW_FSTBOUND: p = {32'hfffe_0000, 32'h3876_0000};
      ROW_AMO:      p = {32'hfff0_0000, 32'h3860_0000};
      ROW_AMO_DB:   p = {32'hfffe_0000, 32'h3870_0000};
      ROW_IBAR:     p = {32'hffff_8000, 32'h3872_8000};
      ROW_DBAR:     p = {32'hffff_8000, 32'h3872_0000};
      ROW_CACOP:    p = {32'hffc0_0000, 32'h0600_0000};
      default:      p = {32'hffff_8000, 32'h0649_8000};   // invtlb
    endcase
    return p;
  endfunction

  function automatic int match_row(input logic [31:0] op);
    pattern_t p;
    int       row;
    int       hit;
    hit = ROW_NONE;
    for (row = 0; row < NUM_ROWS; row++)
    begin
      p = pattern_row(row);
      if ((op & p.mask) == p.value)
        hit = row;
    end
    return hit;
  endfunction

  //============================================================
  //  reference model
  //============================================================
  function automatic pipe4_pkg::ls_size_e model_size(input int row, input logic [31:0] op);
    logic [1:0] sz;
    case (row)
      ROW_SC, ROW_STPTR:                  sz = {1'b1, op[25]};
      ROW_ST:                             sz = op[23:22];
      ROW_FST:                            sz = {1'b1, op[23]};
      ROW_STX:                            sz = op[19:18];
      ROW_FSTX:                           sz = {1'b1, op[18]};
      ROW_STBOUND:                        sz = op[16:15];
      ROW_FSTBOUND, ROW_AMO, ROW_AMO_DB:  sz = {1'b1, op[15]};   // word or dword
      ROW_CACOP:                          sz = 2'b11;
      default:                            sz = 2'b00;
    endcase
    return pipe4_pkg::ls_size_e'(sz);
  endfunction

  function automatic pipe4_pkg::decd_out_t model_decd(input logic [31:0] op,
                                                      input logic [6:0]  preg);
    pipe4_pkg::decd_out_t d;
    int                   row;
    logic                 fp;
    row     = match_row(op);
    fp      = (row == ROW_FST) || (row == ROW_FSTX) || (row == ROW_FSTBOUND);
    d       = '0;
    d.shift = pipe4_pkg::SHIFT_IMM;
    d.size  = model_size(row, op);
    case (row)
      ROW_ST, ROW_FST, ROW_STPTR:
      begin
        d.st      = 1'b1;
        d.mmu_req = 1'b1;
        d.lsfifo  = 1'b1;
        if (row == ROW_STPTR)
        begin
          d.offset = op[23:10];
          d.shift  = pipe4_pkg::SHIFT_IMM4;
        end
        else
        begin
          d.fls    = fp;
          d.offset = op[21] ? {2'b11, op[21:10]} : {2'b00, op[21:10]};
        end
      end
      ROW_SC:
      begin
        d.atomic     = 1'b1;
        d.st         = 1'b1;
        d.mmu_req    = 1'b1;
        d.icc        = preg[6];
        d.mode       = preg[5:4];
        d.fence_mode = preg[3:0];
        d.inst_type  = pipe4_pkg::TYPE_ICACHE;
        d.offset     = op[23:10];
        d.shift      = pipe4_pkg::SHIFT_IMM4;
      end
      ROW_STX, ROW_FSTX, ROW_STBOUND, ROW_FSTBOUND:
      begin
        d.st      = 1'b1;
        d.mmu_req = 1'b1;
        d.lsfifo  = 1'b1;
        d.fls     = fp;
        d.str     = (row == ROW_STX || row == ROW_FSTX) ? 1'b1 : fp;   // bound forms only if float
      end
      ROW_AMO, ROW_AMO_DB:
      begin
        d.atomic = 1'b1;
        d.st     = 1'b1;
      end
      ROW_IBAR, ROW_DBAR, ROW_INVTLB:
      begin
        d.share      = 1'b1;
        d.icc        = (row != ROW_DBAR);
        d.sync_fence = (row == ROW_DBAR);
        if (row != ROW_INVTLB)
          d.inst_type = pipe4_pkg::TYPE_ICACHE;
        if (row == ROW_DBAR)
          d.fence_mode = 4'b1111;
      end
      ROW_CACOP:
      begin
        d.sync_fence = 1'b1;
        d.icc        = 1'b1;
        d.inst_type  = pipe4_pkg::TYPE_DCACHE;
      end
      default:
      begin
        d.illegal = 1'b1;
      end
    endcase
    return d;
  endfunction

  function automatic pipe4_pkg::offset_plus_t model_offset_plus(input pipe4_pkg::decd_out_t d);
    int off;
    int inc;
    off = d.offset[13] ? int'(d.offset) - 16384 : int'(d.offset);   // signed 14-bit value
    inc = (d.shift == pipe4_pkg::SHIFT_IMM4) ? 4 : 16;
    return pipe4_pkg::offset_plus_t'(off + inc);
  endfunction

  //============================================================
  //  checks
  //============================================================
  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_decd(input pipe4_pkg::decd_out_t got, input pipe4_pkg::decd_out_t exp,
                            input logic [31:0] op);
    if (got !== exp)
    begin
      $display("[ERROR] %0d ns: decd mismatch for opcode %h, got %h expected %h",
               $time, op, got, exp);
      abort_run();
    end
  endtask

  task automatic check_offset_plus(input pipe4_pkg::offset_plus_t got,
                                   input pipe4_pkg::offset_plus_t exp, input logic [31:0] op);
    if (got !== exp)
    begin
      $display("[ERROR] %0d ns: offset plus mismatch for opcode %h, got %h expected %h",
               $time, op, got, exp);
      abort_run();
    end
  endtask

  // outputs are settled by the falling edge
  task automatic check_outputs();
    expect_t e;
    if (decd_vld)
    begin
      if (exp_queue.size() == 0)
      begin
        $display("decd_vld went high at %0d ns with no input waiting for it", $time);
        abort_run();
      end
      else
      begin
        e = exp_queue.pop_front();
        check_decd(decd, e.decd, e.opcode);
        check_offset_plus(decd_offset_plus, e.offset_plus, e.opcode);
        checked_count++;
      end
    end
  endtask

  //============================================================
  //  stimulus
  //============================================================
  task automatic drive_cycle();
    pattern_t pat;
    expect_t  e;
    rng_state  = xorshift32(rng_state);
    opcode_vld = (rng_state[1:0] != 2'b00);   // about three in four
    rng_state  = xorshift32(rng_state);
    if (rng_state[2:0] == 3'd0)
    begin
      rng_state = xorshift32(rng_state);
      opcode    = rng_state;   // fully random word
    end
    else
    begin
      pat       = pattern_row(int'(rng_state % NUM_ROWS));
      rng_state = xorshift32(rng_state);
      opcode    = pat.value | (rng_state & ~pat.mask);
    end
    rng_state = xorshift32(rng_state);
    dst_preg  = rng_state[6:0];
    if (opcode_vld)
    begin
      e.opcode      = opcode;
      e.decd        = model_decd(opcode, dst_preg);
      e.offset_plus = model_offset_plus(e.decd);
      exp_queue.push_back(e);
    end
  endtask

  always @(posedge forever_cpuclk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the run did not finish", cycle_count);
      abort_run();
    end
  end

  initial
  begin
    rst_n         = 1'b0;
    opcode_vld    = 1'b0;
    opcode        = '0;
    dst_preg      = '0;
    rng_state     = 32'h3a74;
    cycle_count   = 0;
    checked_count = 0;
    repeat (4) @(posedge forever_cpuclk);
    @(negedge forever_cpuclk);
    rst_n = 1'b1;
    for (cyc = 0; cyc < NUM_CYCLES; cyc++)
    begin
      check_outputs();
      drive_cycle();
      @(negedge forever_cpuclk);
    end
    opcode_vld = 1'b0;
    // drain the pipe while idle outputs stay low
    repeat (PIPE_DEPTH + 2)
    begin
      check_outputs();
      @(negedge forever_cpuclk);
    end
    if (exp_queue.size() == 0)
    begin
      $display("%0d outputs checked", checked_count);
      $display("TEST OK");
      $finish;
    end
    else
    begin
      $display("%0d expected outputs never appeared", exp_queue.size());
      abort_run();
    end
  end

endmodule

// ==== verilog.f ====
verilog/pipe4_pkg.sv
verilog/pipe4_opcode_match.sv
verilog/pipe4_decd_stage.sv
verilog/pipe4_field_gen.sv
verilog/pipe4_decd_top.sv
verification/pipe4_decd_asserts.sv
verification/pipe4_decd_tb.sv

// ==== verilog/pipe4_decd_stage.sv ====
// fixed-latency shift chain, no stall; PIPE_DEPTH must be 1 or more
`timescale 1ns/100ps
module pipe4_decd_stage #(
  parameter int PIPE_DEPTH = 1   // real depth comes from the top
) (
  input  logic                   forever_cpuclk,
  input  logic                   rst_n,
  input  logic                   in_vld,
  input  pipe4_pkg::decd_entry_t in_entry,
  output logic                   out_vld,
  output pipe4_pkg::decd_entry_t out_entry
);

  logic                   stage_vld   [PIPE_DEPTH];
  pipe4_pkg::decd_entry_t stage_entry [PIPE_DEPTH];

  // valid chain
  always_ff @(posedge forever_cpuclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < PIPE_DEPTH; i++)
        stage_vld[i] <= 1'b0;
    end
    else
    begin
      stage_vld[0] <= in_vld;
      for (int i = 1; i < PIPE_DEPTH; i++)
        stage_vld[i] <= stage_vld[i-1];
    end
  end

  // payload follows valid, captured every cycle
  always_ff @(posedge forever_cpuclk)
  begin
    stage_entry[0] <= in_entry;
    for (int i = 1; i < PIPE_DEPTH; i++)
      stage_entry[i] <= stage_entry[i-1];
  end

  assign out_vld   = stage_vld[PIPE_DEPTH-1];
  assign out_entry = stage_entry[PIPE_DEPTH-1];

endmodule

// ==== verilog/pipe4_decd_top.sv ====
// no back-pressure; each valid input leaves PIPE_DEPTH cycles later, in order
`timescale 1ns/100ps
module pipe4_decd_top #(
  parameter int PIPE_DEPTH = 2
) (
  input  logic                    forever_cpuclk,
  input  logic                    rst_n,
  input  logic                    opcode_vld,
  input  logic [31:0]             opcode,
  input  logic [6:0]              dst_preg,
  output logic                    decd_vld,
  output pipe4_pkg::decd_out_t    decd,
  output pipe4_pkg::offset_plus_t decd_offset_plus
);

  pipe4_pkg::decd_entry_t match_entry;   // producer side
  pipe4_pkg::decd_entry_t stage_entry;   // after the register chain

  pipe4_opcode_match u_match (
    .opcode   (opcode),
    .dst_preg (dst_preg),
    .entry    (match_entry)
  );

  pipe4_decd_stage #(
    .PIPE_DEPTH (PIPE_DEPTH)
  ) u_stage (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .in_vld         (opcode_vld),
    .in_entry       (match_entry),
    .out_vld        (decd_vld),
    .out_entry      (stage_entry)
  );

  pipe4_field_gen u_gen (
    .entry       (stage_entry),
    .decd        (decd),
    .offset_plus (decd_offset_plus)
  );

endmodule

// ==== verilog/pipe4_field_gen.sv ====
// combinational expand of one entry; outputs are meaningful only with the stage valid
`timescale 1ns/100ps
module pipe4_field_gen (
  input  pipe4_pkg::decd_entry_t  entry,
  output pipe4_pkg::decd_out_t    decd,
  output pipe4_pkg::offset_plus_t offset_plus
);

  pipe4_pkg::offset_plus_t plus_value;

  //============================================================
  //  control bundle
  //============================================================
  always_comb
  begin
    decd       = '0;
    decd.shift = pipe4_pkg::SHIFT_IMM;   // no scaling unless a ptr/sc form

    if (entry.illegal)
    begin
      decd.illegal = 1'b1;
    end
    else
    begin
      decd.size = entry.size;
      case (entry.op)
        pipe4_pkg::OP_ST_IMM:
        begin
          decd.st      = 1'b1;
          decd.mmu_req = 1'b1;
          decd.lsfifo  = 1'b1;
          decd.fls     = entry.fp;
          decd.offset  = {{2{entry.imm[11]}}, entry.imm[11:0]};   // 12-bit signed imm
        end

        pipe4_pkg::OP_ST_PTR:
        begin
          decd.st      = 1'b1;
          decd.mmu_req = 1'b1;
          decd.lsfifo  = 1'b1;
          decd.offset  = entry.imm;
          decd.shift   = pipe4_pkg::SHIFT_IMM4;
        end

        pipe4_pkg::OP_ST_COND:
        begin
          decd.atomic     = 1'b1;
          decd.st         = 1'b1;
          decd.mmu_req    = 1'b1;
          // ll/sc side info rides in the preg field
          decd.icc        = entry.preg[6];
          decd.mode       = entry.preg[5:4];
          decd.fence_mode = entry.preg[3:0];
          decd.inst_type  = pipe4_pkg::TYPE_ICACHE;
          decd.offset     = entry.imm;
          decd.shift      = pipe4_pkg::SHIFT_IMM4;
        end

        pipe4_pkg::OP_ST_IDX:
        begin
          decd.st      = 1'b1;
          decd.mmu_req = 1'b1;
          decd.lsfifo  = 1'b1;
          decd.str     = 1'b1;   // address from rk
          decd.fls     = entry.fp;
        end

        pipe4_pkg::OP_ST_BOUND:
        begin
          decd.st      = 1'b1;
          decd.mmu_req = 1'b1;
          decd.lsfifo  = 1'b1;
          decd.str     = entry.fp;   // only the float bound forms
          decd.fls     = entry.fp;
        end

        pipe4_pkg::OP_AMO:
        begin
          decd.atomic = 1'b1;
          decd.st     = 1'b1;
        end

        //------------------------------------------------------
        // barrier and maintenance
        pipe4_pkg::OP_IBAR:
        begin
          decd.share     = 1'b1;
          decd.icc       = 1'b1;
          decd.inst_type = pipe4_pkg::TYPE_ICACHE;
        end

        pipe4_pkg::OP_DBAR:
        begin
          decd.sync_fence = 1'b1;
          decd.share      = 1'b1;
          decd.inst_type  = pipe4_pkg::TYPE_ICACHE;
          decd.fence_mode = pipe4_pkg::FENCE_ALL;
        end

        pipe4_pkg::OP_CACOP:
        begin
          decd.sync_fence = 1'b1;
          decd.icc        = 1'b1;
          decd.inst_type  = pipe4_pkg::TYPE_DCACHE;
          decd.size       = pipe4_pkg::SIZE_DWORD;   // whole line op
        end

        pipe4_pkg::OP_INVTLB:
        begin
          decd.share = 1'b1;
          decd.icc   = 1'b1;
        end

        default:
        begin
          // unknown class code, treat like an unmatched opcode
          decd.size    = pipe4_pkg::SIZE_BYTE;
          decd.illegal = 1'b1;
        end
      endcase
    end
  end

  //============================================================
  //  offset plus increment
  //============================================================
  assign plus_value  = (decd.shift == pipe4_pkg::SHIFT_IMM4) ? pipe4_pkg::PLUS_PTR
                                                              : pipe4_pkg::PLUS_IMM;
  assign offset_plus = {decd.offset[13], decd.offset} + plus_value;   // sign-extend to 15

endmodule

// ==== verilog/pipe4_opcode_match.sv ====
// purely combinational; unmatched opcodes are flagged illegal, fields then ignored downstream
`timescale 1ns/100ps
module pipe4_opcode_match (
  input  logic [31:0]            opcode,
  input  logic [6:0]             dst_preg,
  output pipe4_pkg::decd_entry_t entry
);

  //============================================================
  //  class match on opcode[31:10]
  //============================================================
  always_comb
  begin
    entry.op   = pipe4_pkg::OP_ILLEGAL;
    entry.size = pipe4_pkg::SIZE_BYTE;
    entry.fp   = 1'b0;
    entry.imm  = opcode[23:10];   // raw, shaped later per class
    entry.preg = dst_preg;

    casez (opcode[31:10])
      // sc.w / sc.d, bit 25 picks dword
      22'b001000?1_?????????_?????:
      begin
        entry.op   = pipe4_pkg::OP_ST_COND;
        entry.size = opcode[25] ? pipe4_pkg::SIZE_DWORD : pipe4_pkg::SIZE_WORD;
      end

      // stptr.w / stptr.d
      22'b001001?1_?????????_?????:
      begin
        entry.op   = pipe4_pkg::OP_ST_PTR;
        entry.size = opcode[25] ? pipe4_pkg::SIZE_DWORD : pipe4_pkg::SIZE_WORD;
      end

      // st.b/h/w/d, size sits in bits 23:22
      22'b00101001??_????????????:
      begin
        entry.op   = pipe4_pkg::OP_ST_IMM;
        entry.size = pipe4_pkg::ls_size_e'(opcode[23:22]);
      end

      // fst.s / fst.d
      22'b00101011?1_????????????:
      begin
        entry.op   = pipe4_pkg::OP_ST_IMM;
        entry.size = opcode[23] ? pipe4_pkg::SIZE_DWORD : pipe4_pkg::SIZE_WORD;
        entry.fp   = 1'b1;
      end

      // stx.b/h/w/d
      22'b001110000001??000_?????:
      begin
        entry.op   = pipe4_pkg::OP_ST_IDX;
        entry.size = pipe4_pkg::ls_size_e'(opcode[19:18]);
      end

      // fstx.s / fstx.d
      22'b0011100000111?000_?????:
      begin
        entry.op   = pipe4_pkg::OP_ST_IDX;
        entry.size = opcode[18] ? pipe4_pkg::SIZE_DWORD : pipe4_pkg::SIZE_WORD;
        entry.fp   = 1'b1;
      end

      // stgt/stle .b/h/w/d
      22'b00111000011111???_?????:
      begin
        entry.op   = pipe4_pkg::OP_ST_BOUND;
        entry.size = pipe4_pkg::ls_size_e'(opcode[16:15]);
      end

      // fstgt/fstle .s/.d
      22'b001110000111011??_?????:
      begin
        entry.op   = pipe4_pkg::OP_ST_BOUND;
        entry.size = opcode[15] ? pipe4_pkg::SIZE_DWORD : pipe4_pkg::SIZE_WORD;
        entry.fp   = 1'b1;
      end

      // amo forms plus the low amo_db range, then the last four amo_db
      22'b001110000110?????_?????,
      22'b001110000111000??_?????:
      begin
        entry.op   = pipe4_pkg::OP_AMO;
        entry.size = opcode[15] ? pipe4_pkg::SIZE_DWORD : pipe4_pkg::SIZE_WORD;
      end

      22'b00111000011100101_?????: entry.op = pipe4_pkg::OP_IBAR;
      22'b00111000011100100_?????: entry.op = pipe4_pkg::OP_DBAR;

      22'b0000011000_????????????: entry.op = pipe4_pkg::OP_CACOP;

      22'b00000110010010011_?????: entry.op = pipe4_pkg::OP_INVTLB;

      default:
      begin
        entry.op = pipe4_pkg::OP_ILLEGAL;
      end
    endcase

    entry.illegal = (entry.op == pipe4_pkg::OP_ILLEGAL);
  end

endmodule

// ==== verilog/pipe4_pkg.sv ====
// store/amo/barrier classes only; encodings fixed, no load or vector forms
package pipe4_pkg;

  //============================================================
  //  instruction classes and access attributes
  //============================================================
  typedef enum logic [3:0] {
    OP_ST_IMM,    // st.b/h/w/d, fst.s/d
    OP_ST_PTR,    // stptr.w/d
    OP_ST_COND,   // sc.w/d
    OP_ST_IDX,    // stx, fstx
    OP_ST_BOUND,  // stgt/stle, fstgt/fstle
    OP_AMO,       // amo and amo_db together
    OP_IBAR,
    OP_DBAR,
    OP_CACOP,
    OP_INVTLB,
    OP_ILLEGAL
  } ls_op_e;

  typedef enum logic [1:0] {
    SIZE_BYTE  = 2'b00,
    SIZE_HALF  = 2'b01,
    SIZE_WORD  = 2'b10,
    SIZE_DWORD = 2'b11
  } ls_size_e;

  typedef enum logic [1:0] {
    TYPE_NORM   = 2'b00,
    TYPE_ICACHE = 2'b01,
    TYPE_DCACHE = 2'b10
  } inst_type_e;

  // one-hot scale applied to the offset downstream
  typedef enum logic [3:0] {
    SHIFT_IMM  = 4'b0001,
    SHIFT_IMM4 = 4'b0100
  } shift_e;

  //============================================================
  //  stage payloads
  //============================================================
  typedef struct packed {
    ls_op_e      op;
    ls_size_e    size;
    logic        fp;       // float store variant
    logic [13:0] imm;      // opcode[23:10]
    logic [6:0]  preg;
    logic        illegal;
  } decd_entry_t;

  typedef struct packed {
    logic        illegal;
    logic        atomic;
    logic        sync_fence;
    logic        share;
    logic        icc;
    logic        st;
    logic        mmu_req;
    logic        fls;
    logic        str;
    logic        lsfifo;
    inst_type_e  inst_type;
    ls_size_e    size;
    logic [1:0]  mode;
    logic [3:0]  fence_mode;
    shift_e      shift;
    logic [13:0] offset;
  } decd_out_t;

  typedef logic [14:0] offset_plus_t;

  // offset increments, pointer form vs. plain immediate
  localparam offset_plus_t PLUS_PTR = 15'd4;
  localparam offset_plus_t PLUS_IMM = 15'd16;

  localparam logic [3:0] FENCE_ALL = 4'b1111;

endpackage
